// ==== project.f ====
hdl/wht_pkg.sv
hdl/srl_delay.sv
hdl/wht_dual_port_ram.sv
hdl/wht_apb_config.sv
hdl/wht_tap_sequencer.sv
hdl/wht_table.sv
hdl/wht_subsystem_top.sv
sim/wht_tb.sv

// ==== sim/wht_tb.sv ====
`timescale 1ns/100ps

module wht_tb;

    import wht_pkg::*;

    localparam int CLK_HALF   = 10;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RST_CYCLES = 5;
    localparam int SEED       = 26334;

    // Run beats plus two bus cycles per weight write plus slack
    function automatic int test_cycles(input int beats, input int writes);
        return beats + 2 * writes + 200;
    endfunction

    localparam int WATCHDOG_CYCLES = test_cycles(0, 0) + test_cycles(20, 36)
                                   + test_cycles(60, 0) + test_cycles(30, 0)
                                   + test_cycles(20, 1) + test_cycles(320, 576);

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    wht_out_t wht_out;

    // Reference copy of every weight written
    logic [WEIGHT_WIDTH-1:0] model [TBL_DEPTH];

    // Expected output stream
    wht_out_t exp_q [$];
    wht_out_t exp_beat;
    logic     exp_avail;
    int       exp_left;

    // Expected bus response for the current access cycle
    logic                      exp_err;
    logic                      rd_chk;
    logic [APB_DATA_WIDTH-1:0] exp_rdata;
    logic                      start_mark;

    int err_count;
    int test_base;
    int tests_run;
    int run_beats;

    always #CLK_HALF clk = ~clk;

    wht_subsystem_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .wht_out (wht_out)
    );

    //////////////////////////////
    // Output stream tracking
    //////////////////////////////

    // Pop the model beat while wht_out is stable mid-cycle
    always @(negedge clk) begin
        if (wht_out.valid && !rst) begin
            run_beats++;
            if (exp_q.size() > 0) begin
                exp_beat  = exp_q.pop_front();
                exp_avail = 1'b1;
            end else begin
                exp_avail = 1'b0;
            end
        end else begin
            exp_avail = 1'b0;
        end
        exp_left = exp_q.size();
    end

    //////////////////////////////
    // Checking assertions
    //////////////////////////////
    a_pslverr: assert property (
        @(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |-> (apb_rsp.pslverr == exp_err)
    ) else begin
        $display("Error apb_rsp.pslverr got %h expected %h",
                 $sampled(apb_rsp.pslverr), $sampled(exp_err));
        err_count++;
    end

    // Zero wait states on every transfer
    a_pready: assert property (
        @(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
    ) else begin
        $display("Error apb_rsp.pready got %h expected 1", $sampled(apb_rsp.pready));
        err_count++;
    end

    a_prdata: assert property (
        @(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable && !apb_req.pwrite && rd_chk)
            |-> (apb_rsp.prdata == exp_rdata)
    ) else begin
        $display("Error apb_rsp.prdata got %h expected %h",
                 $sampled(apb_rsp.prdata), $sampled(exp_rdata));
        err_count++;
    end

    // One cycle to the first request, then the table pipeline
    a_first_beat: assert property (
        @(posedge clk) disable iff (rst)
        start_mark |-> ##1 (!wht_out.valid) [*WHT_PIPE_LATENCY] ##1 wht_out.valid
    ) else begin
        $display("First output beat did not arrive exactly 7 cycles after the start");
        err_count++;
    end

    a_expected: assert property (
        @(posedge clk) disable iff (rst)
        wht_out.valid |-> exp_avail
    ) else begin
        $display("Output beat arrived while no beat was expected");
        err_count++;
    end

    // No gaps while beats remain
    a_contig: assert property (
        @(posedge clk) disable iff (rst)
        (wht_out.valid && exp_left > 0) |=> wht_out.valid
    ) else begin
        $display("Output stream has a gap while beats are still expected");
        err_count++;
    end

    a_w0: assert property (
        @(posedge clk) disable iff (rst)
        (wht_out.valid && exp_avail) |-> (wht_out.w0 == exp_beat.w0)
    ) else begin
        $display("Error wht_out.w0 got %h expected %h",
                 $sampled(wht_out.w0), $sampled(exp_beat.w0));
        err_count++;
    end

    a_w1: assert property (
        @(posedge clk) disable iff (rst)
        (wht_out.valid && exp_avail) |-> (wht_out.w1 == exp_beat.w1)
    ) else begin
        $display("Error wht_out.w1 got %h expected %h",
                 $sampled(wht_out.w1), $sampled(exp_beat.w1));
        err_count++;
    end

    a_kernel_end: assert property (
        @(posedge clk) disable iff (rst)
        (wht_out.valid && exp_avail) |-> (wht_out.kernel_end == exp_beat.kernel_end)
    ) else begin
        $display("Error wht_out.kernel_end got %h expected %h",
                 $sampled(wht_out.kernel_end), $sampled(exp_beat.kernel_end));
        err_count++;
    end

    a_last_kernel: assert property (
        @(posedge clk) disable iff (rst)
        (wht_out.valid && exp_avail) |-> (wht_out.last_kernel == exp_beat.last_kernel)
    ) else begin
        $display("Error wht_out.last_kernel got %h expected %h",
                 $sampled(wht_out.last_kernel), $sampled(exp_beat.last_kernel));
        err_count++;
    end

    //////////////////////////////
    // Bus tasks
    //////////////////////////////

    // Starts and ends on a falling edge, so transfers run back to back
    task automatic apb_xfer(
        input  logic                      write,
        input  logic [APB_ADDR_WIDTH-1:0] addr,
        input  logic [APB_DATA_WIDTH-1:0] wdata,
        input  logic                      err,
        input  logic                      chk,
        input  logic [APB_DATA_WIDTH-1:0] rd_exp,
        input  logic                      mark,
        output logic [APB_DATA_WIDTH-1:0] rdata
    );
        // Setup cycle
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        // Access cycle
        apb_req.penable = 1'b1;
        exp_err         = err;
        rd_chk          = chk;
        exp_rdata       = rd_exp;
        start_mark      = mark;
        @(negedge clk);
        rdata           = apb_rsp.prdata;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        exp_err         = 1'b0;
        rd_chk          = 1'b0;
        start_mark      = 1'b0;
    endtask

    task automatic apb_write(
        input logic [APB_ADDR_WIDTH-1:0] addr,
        input logic [APB_DATA_WIDTH-1:0] data,
        input logic                      err
    );
        logic [APB_DATA_WIDTH-1:0] unused;
        apb_xfer(1'b1, addr, data, err, 1'b0, '0, 1'b0, unused);
    endtask

    task automatic apb_read_check(
        input logic [APB_ADDR_WIDTH-1:0] addr,
        input logic [APB_DATA_WIDTH-1:0] exp,
        input logic                      err
    );
        logic [APB_DATA_WIDTH-1:0] unused;
        apb_xfer(1'b0, addr, '0, err, 1'b1, exp, 1'b0, unused);
    endtask

    //////////////////////////////
    // Model and job tasks
    //////////////////////////////

    // Table address is {group, tap}
    function automatic int tbl_index(input int group, input int tap);
        return group * (1 << TAP_ADDR_WIDTH) + tap;
    endfunction

    task automatic load_kernels(input int count);
        logic [WEIGHT_WIDTH-1:0] w;
        // Config-mode start rewinds the fill pointer
        apb_write(REG_CTRL, 32'h3, 1'b0);
        for (int g = 0; g < count; g++) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                w = WEIGHT_WIDTH'($urandom());
                model[tbl_index(g, t)] = w;
                apb_write(REG_WEIGHT, APB_DATA_WIDTH'(w), 1'b0);
            end
        end
    endtask

    // Pair j reads taps 2j and 2j+1, last pair reads tap 8 twice
    task automatic push_run(input int kernels, input int passes);
        wht_out_t b;
        int       t1;
        for (int p = 0; p < passes; p++) begin
            for (int k = 0; k < kernels; k++) begin
                for (int j = 0; j < TAP_PAIRS; j++) begin
                    t1            = (j == TAP_PAIRS - 1) ? KERNEL_TAPS - 1 : 2 * j + 1;
                    b.valid       = 1'b1;
                    b.kernel_end  = (j == TAP_PAIRS - 1);
                    b.last_kernel = (k == kernels - 1);
                    b.w0          = model[tbl_index(k, 2 * j)];
                    b.w1          = model[tbl_index(k, t1)];
                    exp_q.push_back(b);
                end
            end
        end
    endtask

    task automatic start_job(input int kernels, input int passes);
        logic [APB_DATA_WIDTH-1:0] unused;
        apb_write(REG_NUM_KERNELS, APB_DATA_WIDTH'(kernels), 1'b0);
        apb_write(REG_NUM_PASSES, APB_DATA_WIDTH'(passes), 1'b0);
        push_run(kernels, passes);
        run_beats = 0;
        // Mode 0 with start bit
        apb_xfer(1'b1, REG_CTRL, 32'h2, 1'b0, 1'b0, '0, 1'b1, unused);
    endtask

    // Poll busy, then let the pipeline drain
    task automatic wait_done(input int total);
        int                        polls;
        logic [APB_DATA_WIDTH-1:0] st;
        polls = 0;
        st    = 32'h1;
        while (st[0] && polls < total + 50) begin
            apb_xfer(1'b0, REG_STATUS, '0, 1'b0, 1'b0, '0, 1'b0, st);
            polls++;
        end
        a_busy_clear: assert (!st[0]) else begin
            $display("Sequencer stayed busy after the run should have ended");
            err_count++;
        end
        for (int i = 0; i < WHT_PIPE_LATENCY + 4 && exp_q.size() > 0; i++) begin
            @(negedge clk);
        end
        a_drained: assert (exp_q.size() == 0) else begin
            $display("Output stream stopped with %0d beats still expected", exp_q.size());
            err_count++;
        end
        a_beat_count: assert (run_beats == total) else begin
            $display("Error run_beats got %h expected %h", run_beats, total);
            err_count++;
        end
        apb_read_check(REG_STATUS, '0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d error(s)", name, err_count - test_base);
        test_base = err_count;
        tests_run++;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        apb_req    = '0;
        exp_err    = 1'b0;
        rd_chk     = 1'b0;
        exp_rdata  = '0;
        start_mark = 1'b0;
        exp_avail  = 1'b0;
        exp_left   = 0;
        err_count  = 0;
        test_base  = 0;
        tests_run  = 0;
        run_beats  = 0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle outputs, register readback, bad offsets and counts
        a_idle_valid: assert (!wht_out.valid) else begin
            $display("Error wht_out.valid got %h expected 0", wht_out.valid);
            err_count++;
        end
        a_idle_err: assert (!apb_rsp.pslverr) else begin
            $display("Error apb_rsp.pslverr got %h expected 0", apb_rsp.pslverr);
            err_count++;
        end
        apb_write(REG_NUM_KERNELS, 32'd5, 1'b0);
        apb_read_check(REG_NUM_KERNELS, 32'd5, 1'b0);
        apb_write(REG_NUM_PASSES, 32'h1234, 1'b0);
        apb_read_check(REG_NUM_PASSES, 32'h1234, 1'b0);
        apb_read_check(8'h14, '0, 1'b1);
        apb_write(REG_NUM_KERNELS, 32'd0, 1'b1);
        apb_write(REG_NUM_KERNELS, 32'd65, 1'b1);
        apb_read_check(REG_NUM_KERNELS, 32'd5, 1'b0);
        finish_test("reset and registers");

        load_kernels(4);
        start_job(4, 1);
        wait_done(20);
        finish_test("load and single pass");

        // Group wraps each pass
        start_job(4, 3);
        wait_done(60);
        finish_test("three passes");

        start_job(3, 2);
        wait_done(30);
        finish_test("start latency and beat count");

        // Rejected weight write and rejected restart
        apb_write(REG_WEIGHT, 32'hdead, 1'b1);
        start_job(4, 1);
        apb_write(REG_CTRL, 32'h2, 1'b1);
        wait_done(20);
        finish_test("bus errors");

        // Full table up to the top group
        load_kernels(KERNELS_MAX);
        start_job(KERNELS_MAX, 1);
        wait_done(KERNELS_MAX * TAP_PAIRS);
        finish_test("full table");

        $display("Tests run: %0d, errors: %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== hdl/wht_subsystem_top.sv ====
`timescale 1ns/100ps

module wht_subsystem_top (
    input  logic              clk,
    input  logic              rst,
    input  wht_pkg::apb_req_t apb_req,
    output wht_pkg::apb_rsp_t apb_rsp,
    output wht_pkg::wht_out_t wht_out
);

    import wht_pkg::*;

    // Config slave outputs
    logic                    config_mode;
    logic                    job_accept;
    wht_cfg_t                wht_cfg;
    logic [KCOUNT_WIDTH-1:0] num_kernels;
    logic [PASS_WIDTH-1:0]   num_passes;

    // Sequencer outputs
    seq_req_t                seq_req;
    logic                    busy;

    wht_apb_config u_apb_config (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .busy        (busy),
        .config_mode (config_mode),
        .job_accept  (job_accept),
        .wht_cfg     (wht_cfg),
        .num_kernels (num_kernels),
        .num_passes  (num_passes)
    );

    wht_tap_sequencer u_tap_sequencer (
        .clk         (clk),
        .rst         (rst),
        .job_accept  (job_accept),
        .config_mode (config_mode),
        .num_kernels (num_kernels),
        .num_passes  (num_passes),
        .seq_req     (seq_req),
        .busy        (busy)
    );

    // Weight stream out, one beat per request
    wht_table u_table (
        .clk         (clk),
        .rst         (rst),
        .config_mode (config_mode),
        .job_accept  (job_accept),
        .num_kernels (num_kernels),
        .wht_cfg     (wht_cfg),
        .seq_req     (seq_req),
        .wht_out     (wht_out)
    );

endmodule

// ==== hdl/wht_table.sv ====
`timescale 1ns/100ps

module wht_table (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              config_mode,
    input  logic                              job_accept,
    input  logic [wht_pkg::KCOUNT_WIDTH-1:0]  num_kernels,
    input  wht_pkg::wht_cfg_t                 wht_cfg,
    input  wht_pkg::seq_req_t                 seq_req,
    output wht_pkg::wht_out_t                 wht_out
);

    import wht_pkg::*;

    logic [TAP_ADDR_WIDTH-1:0] fill_count;
    logic [GROUP_WIDTH-1:0]    kernel_group;
    logic [GROUP_WIDTH-1:0]    group_last;
    logic [TAP_ADDR_WIDTH-1:0] tap0;
    logic [TAP_ADDR_WIDTH-1:0] tap1;
    logic [TBL_ADDR_WIDTH-1:0] addr0_w;
    logic [TBL_ADDR_WIDTH-1:0] addr1_w;
    logic [TBL_ADDR_WIDTH-1:0] addr0_d;
    logic [TBL_ADDR_WIDTH-1:0] addr1_d;
    logic [TBL_ADDR_WIDTH-1:0] addr_cfg;
    logic [TBL_ADDR_WIDTH-1:0] addr_a;
    logic [1:0]                flags_w;
    logic [1:0]                flags_d;
    logic                      valid_d;
    logic [WEIGHT_WIDTH-1:0]   dout0;
    logic [WEIGHT_WIDTH-1:0]   dout1;

    //////////////////////////////
    // Fill pointer and kernel group
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_count   <= '0;
            kernel_group <= '0;
            group_last   <= '0;
        end else if (job_accept) begin
            fill_count   <= '0;
            kernel_group <= '0;
            group_last   <= GROUP_WIDTH'(num_kernels - 1'b1);
        end else if (wht_cfg.wren) begin
            // Nine writes fill one kernel
            if (fill_count == TAP_ADDR_WIDTH'(KERNEL_TAPS - 1)) begin
                fill_count   <= '0;
                kernel_group <= kernel_group + 1'b1;
            end else begin
                fill_count <= fill_count + 1'b1;
            end
        end else if (seq_req.valid && seq_req.last_tap) begin
            // Next kernel, wrap for the next pass
            if (kernel_group == group_last) begin
                kernel_group <= '0;
            end else begin
                kernel_group <= kernel_group + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Address forming
    //////////////////////////////

    // Idle beats park on unused slot 15, away from the fill slots
    assign tap0    = seq_req.valid ? seq_req.addr0 : '1;
    assign tap1    = seq_req.valid ? seq_req.addr1 : '1;
    assign addr0_w = {kernel_group, tap0};
    assign addr1_w = {kernel_group, tap1};

    assign addr_cfg = {kernel_group, fill_count};

    srl_delay #(
        .DEPTH (SEQ_ADDR_DELAY),
        .WIDTH (2 * TBL_ADDR_WIDTH)
    ) u_addr_delay (
        .clk  (clk),
        .rst  (rst),
        .din  ({addr1_w, addr0_w}),
        .dout ({addr1_d, addr0_d})
    );

    // Port A serves the fill in config mode
    assign addr_a = config_mode ? addr_cfg : addr0_d;

    //////////////////////////////
    // Flag alignment
    //////////////////////////////
    assign flags_w[1] = seq_req.valid & seq_req.last_tap;
    assign flags_w[0] = seq_req.valid & (kernel_group == group_last);

    // Flags and valid match the address delay plus RAM read
    srl_delay #(
        .DEPTH (WHT_PIPE_LATENCY),
        .WIDTH (2)
    ) u_flag_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (flags_w),
        .dout (flags_d)
    );

    srl_delay #(
        .DEPTH (WHT_PIPE_LATENCY),
        .WIDTH (1)
    ) u_valid_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (seq_req.valid),
        .dout (valid_d)
    );

    wht_dual_port_ram u_ram (
        .clk    (clk),
        .addr_a (addr_a),
        .wren_a (wht_cfg.wren),
        .din_a  (wht_cfg.data),
        .dout_a (dout0),
        .addr_b (addr1_d),
        .dout_b (dout1)
    );

    always_comb begin
        wht_out.valid       = valid_d;
        wht_out.kernel_end  = flags_d[1];
        wht_out.last_kernel = flags_d[0];
        wht_out.w1          = dout1;
        wht_out.w0          = dout0;
    end

endmodule

// ==== hdl/wht_tap_sequencer.sv ====
`timescale 1ns/100ps

module wht_tap_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              job_accept,
    input  logic                              config_mode,
    input  logic [wht_pkg::KCOUNT_WIDTH-1:0]  num_kernels,
    input  logic [wht_pkg::PASS_WIDTH-1:0]    num_passes,
    output wht_pkg::seq_req_t                 seq_req,
    output logic                              busy
);

    import wht_pkg::*;

    logic                   running;
    logic [PAIR_WIDTH-1:0]  pair;
    logic [GROUP_WIDTH-1:0] kernel;
    logic [PASS_WIDTH-1:0]  pass;
    logic [GROUP_WIDTH-1:0] kernel_last;
    logic [PASS_WIDTH-1:0]  pass_last;
    logic                   pair_last;

    assign pair_last = (pair == PAIR_WIDTH'(TAP_PAIRS - 1));

    //////////////////////////////
    // Pass / kernel / pair counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pair    <= '0;
            kernel  <= '0;
            pass    <= '0;
        end else if (job_accept) begin
            // Load mode start only clears the table pointers
            running <= !config_mode && (num_passes != '0);
            pair    <= '0;
            kernel  <= '0;
            pass    <= '0;
        end else if (running) begin
            if (pair_last) begin
                pair <= '0;
                if (kernel == kernel_last) begin
                    kernel <= '0;
                    // Final request of final pass
                    if (pass == pass_last) begin
                        running <= 1'b0;
                    end else begin
                        pass <= pass + 1'b1;
                    end
                end else begin
                    kernel <= kernel + 1'b1;
                end
            end else begin
                pair <= pair + 1'b1;
            end
        end
    end

    // Terminal counts taken at start
    always_ff @(posedge clk) begin
        if (job_accept) begin
            kernel_last <= GROUP_WIDTH'(num_kernels - 1'b1);
            pass_last   <= num_passes - 1'b1;
        end
    end

    // Pair k reads taps 2k and 2k+1, last pair reads tap 8 twice
    always_comb begin
        seq_req.valid    = running;
        seq_req.addr0    = {pair, 1'b0};
        seq_req.addr1    = pair_last ? TAP_ADDR_WIDTH'(KERNEL_TAPS - 1) : {pair, 1'b1};
        seq_req.last_tap = pair_last;
    end

    assign busy = running;

    a_tap_range: assert property (
        @(posedge clk) disable iff (rst)
        seq_req.valid |-> (seq_req.addr0 <= KERNEL_TAPS - 1) && (seq_req.addr1 <= KERNEL_TAPS - 1)
    ) else $error("Error tap address addr0=%h addr1=%h", seq_req.addr0, seq_req.addr1);

    // Loading and running never overlap
    a_no_req_in_config: assert property (
        @(posedge clk) disable iff (rst)
        config_mode |-> !seq_req.valid
    ) else $error("Error seq_req.valid=%h in config mode", seq_req.valid);

endmodule

// ==== hdl/wht_apb_config.sv ====
`timescale 1ns/100ps

module wht_apb_config (
    input  logic                               clk,
    input  logic                               rst,
    input  wht_pkg::apb_req_t                  apb_req,
    output wht_pkg::apb_rsp_t                  apb_rsp,
    input  logic                               busy,
    output logic                               config_mode,
    output logic                               job_accept,
    output wht_pkg::wht_cfg_t                  wht_cfg,
    output logic [wht_pkg::KCOUNT_WIDTH-1:0]   num_kernels,
    output logic [wht_pkg::PASS_WIDTH-1:0]     num_passes
);

    import wht_pkg::*;

    logic                      access;
    logic                      wr;
    logic                      mapped;
    logic                      ctrl_wr;
    logic                      start_req;
    logic                      weight_wr;
    logic                      err_unmapped;
    logic                      err_weight;
    logic                      err_start;
    logic                      err_kernels;
    logic                      config_mode_r;
    logic [APB_DATA_WIDTH-1:0] rd_data;

    //////////////////////////////
    // Access decode
    //////////////////////////////

    // Access phase, psel and penable both high
    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;

    always_comb begin
        case (apb_req.paddr)
            REG_CTRL,
            REG_NUM_KERNELS,
            REG_NUM_PASSES,
            REG_WEIGHT,
            REG_STATUS: mapped = 1'b1;
            default:    mapped = 1'b0;
        endcase
    end

    // Mode bit frozen while a job runs
    assign ctrl_wr   = wr && (apb_req.paddr == REG_CTRL) && !busy;
    assign start_req = wr && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[CTRL_START_BIT];
    assign weight_wr = wr && (apb_req.paddr == REG_WEIGHT);

    // Error cases
    assign err_unmapped = access && !mapped;
    assign err_weight   = weight_wr && !config_mode_r;
    assign err_start    = start_req && busy;
    assign err_kernels  = wr && (apb_req.paddr == REG_NUM_KERNELS)
                          && ((apb_req.pwdata == '0) || (apb_req.pwdata > KERNELS_MAX));

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            config_mode_r <= 1'b0;
            num_kernels   <= KCOUNT_WIDTH'(1);
            num_passes    <= PASS_WIDTH'(1);
        end else begin
            if (ctrl_wr) begin
                config_mode_r <= apb_req.pwdata[CTRL_MODE_BIT];
            end
            if (wr && (apb_req.paddr == REG_NUM_KERNELS) && !err_kernels) begin
                num_kernels <= apb_req.pwdata[KCOUNT_WIDTH-1:0];
            end
            if (wr && (apb_req.paddr == REG_NUM_PASSES)) begin
                num_passes <= apb_req.pwdata[PASS_WIDTH-1:0];
            end
        end
    end

    // Written mode is seen in the start cycle itself
    assign config_mode = ctrl_wr ? apb_req.pwdata[CTRL_MODE_BIT] : config_mode_r;

    // Start pulse in the access cycle
    assign job_accept = start_req && !busy;

    // Weight write only in config mode
    always_comb begin
        wht_cfg.wren = weight_wr && config_mode_r;
        wht_cfg.data = apb_req.pwdata[WEIGHT_WIDTH-1:0];
    end

    //////////////////////////////
    // Read data and response
    //////////////////////////////
    always_comb begin
        rd_data = '0;
        case (apb_req.paddr)
            REG_CTRL:        rd_data[CTRL_MODE_BIT] = config_mode_r;
            REG_NUM_KERNELS: rd_data[KCOUNT_WIDTH-1:0] = num_kernels;
            REG_NUM_PASSES:  rd_data[PASS_WIDTH-1:0] = num_passes;
            REG_STATUS:      rd_data[0] = busy;
            // weight port reads as zero
            default:         rd_data = '0;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = rd_data;
        // Zero wait states
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = err_unmapped | err_weight | err_start | err_kernels;
    end

    // Access phase always follows a setup phase
    a_apb_setup: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> $past(apb_req.psel && !apb_req.penable)
    ) else $error("Error penable=%h without a setup cycle", apb_req.penable);

endmodule

// ==== hdl/wht_dual_port_ram.sv ====
`timescale 1ns/100ps

module wht_dual_port_ram (
    input  logic                                clk,
    input  logic [wht_pkg::TBL_ADDR_WIDTH-1:0]  addr_a,
    input  logic                                wren_a,
    input  logic [wht_pkg::WEIGHT_WIDTH-1:0]    din_a,
    output logic [wht_pkg::WEIGHT_WIDTH-1:0]    dout_a,
    input  logic [wht_pkg::TBL_ADDR_WIDTH-1:0]  addr_b,
    output logic [wht_pkg::WEIGHT_WIDTH-1:0]    dout_b
);

    import wht_pkg::*;

    logic [WEIGHT_WIDTH-1:0] mem [TBL_DEPTH];

    // Read pipelines, stage 0 is the array output register
    logic [WEIGHT_WIDTH-1:0] rd_a [RAM_READ_LATENCY];
    logic [WEIGHT_WIDTH-1:0] rd_b [RAM_READ_LATENCY];

    // Port A writes and reads, old data on a write
    always_ff @(posedge clk) begin
        if (wren_a) begin
            mem[addr_a] <= din_a;
        end
        rd_a[0] <= mem[addr_a];
        for (int i = 1; i < RAM_READ_LATENCY; i++) begin
            rd_a[i] <= rd_a[i-1];
        end
    end

    // Port B read only
    always_ff @(posedge clk) begin
        rd_b[0] <= mem[addr_b];
        for (int i = 1; i < RAM_READ_LATENCY; i++) begin
            rd_b[i] <= rd_b[i-1];
        end
    end

    assign dout_a = rd_a[RAM_READ_LATENCY-1];
    assign dout_b = rd_b[RAM_READ_LATENCY-1];

    // Config fill must never hit the slot port B is reading
    a_no_collision: assert property (
        @(posedge clk) wren_a |-> (addr_b != addr_a)
    ) else $error("Error wren_a with addr_a=%h equal to addr_b=%h", addr_a, addr_b);

endmodule

// ==== hdl/srl_delay.sv ====
`timescale 1ns/100ps

module srl_delay #(
    parameter int DEPTH = 3,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // One register per cycle of delay
    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            // Shift toward the output end
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Oldest entry leaves
    assign dout = stage[DEPTH-1];

endmodule

// ==== hdl/wht_pkg.sv ====
package wht_pkg;

    //////////////////////////////
    // Table geometry
    //////////////////////////////
    localparam int WEIGHT_WIDTH   = 16;
    localparam int KERNEL_TAPS    = 9;
    localparam int TAP_PAIRS      = 5;
    localparam int PAIR_WIDTH     = 3;
    // 16 slots per kernel, only 0..8 hold weights
    localparam int TAP_ADDR_WIDTH = 4;
    localparam int GROUP_WIDTH    = 6;
    localparam int KERNELS_MAX    = 64;
    // Kernel count needs one more bit to hold 64
    localparam int KCOUNT_WIDTH   = GROUP_WIDTH + 1;
    localparam int PASS_WIDTH     = 16;
    // Address is {group, tap}
    localparam int TBL_ADDR_WIDTH = GROUP_WIDTH + TAP_ADDR_WIDTH;
    localparam int TBL_DEPTH      = 1 << TBL_ADDR_WIDTH;

    // Pipeline delays
    localparam int SEQ_ADDR_DELAY   = 3;
    localparam int RAM_READ_LATENCY = 3;
    localparam int WHT_PIPE_LATENCY = SEQ_ADDR_DELAY + RAM_READ_LATENCY;

    //////////////////////////////
    // APB register map
    //////////////////////////////
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL        = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_NUM_KERNELS = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_NUM_PASSES  = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_WEIGHT      = 8'h0C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS      = 8'h10;

    // REG_CTRL bit positions
    localparam int CTRL_MODE_BIT  = 0;
    localparam int CTRL_START_BIT = 1;

    //////////////////////////////
    // Shared structs
    //////////////////////////////
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // One weight write into the table
    typedef struct packed {
        logic                    wren;
        logic [WEIGHT_WIDTH-1:0] data;
    } wht_cfg_t;

    typedef struct packed {
        logic                      valid;
        logic [TAP_ADDR_WIDTH-1:0] addr0;
        logic [TAP_ADDR_WIDTH-1:0] addr1;
        logic                      last_tap;
    } seq_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    kernel_end;
        logic                    last_kernel;
        logic [WEIGHT_WIDTH-1:0] w1;
        logic [WEIGHT_WIDTH-1:0] w0;
    } wht_out_t;

endpackage
